/* logic/helix_pkg.sv */
package helix_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  localparam int DHS_ADDRW = 32;
  localparam int DHS_DATAW = 32;

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  // Region is addr[15:12], word offset is addr[5:2]
  localparam int REGION_LSB = 12;
  localparam int REGION_W   = 4;
  localparam int OFFSET_LSB = 2;
  localparam int OFFSET_W   = 4;

  localparam logic [REGION_W-1:0] SOC_CTRL_REGION = REGION_W'(0);
  localparam logic [REGION_W-1:0] UART_REGION     = REGION_W'(1);

  // Reset boot vector of both cores
  localparam logic [DHS_ADDRW-1:0] BOOT_ROM_BASE = 32'h1000_0000;

  //////////////////////////////////////////////////
  // UART
  //////////////////////////////////////////////////

  localparam int UART_CLKS_PER_BIT = 8;
  localparam int UART_FIFO_DEPTH   = 4;
  localparam int UART_FRAME_BITS   = 10;
  localparam int UART_BAUD_W       = $clog2(UART_CLKS_PER_BIT);
  localparam int UART_PTR_W        = $clog2(UART_FIFO_DEPTH);
  localparam int UART_LVL_W        = UART_PTR_W + 1;

  //////////////////////////////////////////////////
  // Link payloads
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                 write;
    logic [DHS_ADDRW-1:0] addr;
    logic [DHS_DATAW-1:0] wdata;
  } periph_req_t;

  typedef struct packed {
    logic                 err;
    logic [DHS_DATAW-1:0] rdata;
  } periph_rsp_t;

  // One bit per target
  typedef struct packed {
    logic soc_ctrl;
    logic uart;
  } periph_sel_t;

endpackage

/* logic/periph_link.sv */
`timescale 1ns/1ps

module periph_link
  import helix_pkg::*;
(
  input  logic        periphl_clk_i,
  input  logic        reset_i,
  input  logic        req_valid_i,
  input  periph_req_t req_i,
  output periph_sel_t sel_o,
  output periph_req_t fwd_req_o,
  input  periph_rsp_t soc_rsp_i,
  input  periph_rsp_t uart_rsp_i,
  output logic        rsp_valid_o,
  output periph_rsp_t rsp_o
);

  logic [REGION_W-1:0] region;
  periph_sel_t         sel_d;

  // Request stage
  periph_sel_t         sel_q;
  periph_req_t         req_q;
  logic                req_valid_q;

  // Response stage, record of the pending region
  periph_sel_t         rsp_sel_q;
  logic                rsp_valid_q;

  //////////////////////////////////////////////////
  // Region decode
  //////////////////////////////////////////////////

  assign region = req_i.addr[REGION_LSB +: REGION_W];

  always_comb begin
    sel_d = '0;
    if (req_valid_i) begin
      sel_d.soc_ctrl = (region == SOC_CTRL_REGION);
      sel_d.uart     = (region == UART_REGION);
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (reset_i) begin
      sel_q       <= '0;
      req_valid_q <= 1'b0;
    end else begin
      sel_q       <= sel_d;
      req_valid_q <= req_valid_i;
    end
  end

  // Payload shared by both targets
  always_ff @(posedge periphl_clk_i) begin
    if (req_valid_i) begin
      req_q <= req_i;
    end
  end

  assign sel_o     = sel_q;
  assign fwd_req_o = req_q;

  //////////////////////////////////////////////////
  // Response steering
  //////////////////////////////////////////////////

  always_ff @(posedge periphl_clk_i) begin
    if (reset_i) begin
      rsp_sel_q   <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_sel_q   <= sel_q;
      rsp_valid_q <= req_valid_q;
    end
  end

  // No select recorded means the region was unmapped
  always_comb begin
    if (rsp_sel_q.soc_ctrl) begin
      rsp_o = soc_rsp_i;
    end else if (rsp_sel_q.uart) begin
      rsp_o = uart_rsp_i;
    end else begin
      rsp_o.err   = 1'b1;
      rsp_o.rdata = '0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Never more than one target owns a request
  assert property (@(posedge periphl_clk_i) disable iff (reset_i)
    $onehot0(sel_o));

  // Every strobe answered exactly two cycles later, and nothing else
  assert property (@(posedge periphl_clk_i) disable iff (reset_i)
    req_valid_i |-> ##2 rsp_valid_o);

  assert property (@(posedge periphl_clk_i) disable iff (reset_i)
    rsp_valid_o |-> $past(req_valid_i, 2));

endmodule

/* logic/soc_ctrl_regs.sv */
`timescale 1ns/1ps

module soc_ctrl_regs
  import helix_pkg::*;
(
  input  logic                 periphl_clk_i,
  input  logic                 reset_i,
  input  logic                 sel_i,
  input  periph_req_t          req_i,
  input  logic                 boot_mode_i,
  output periph_rsp_t          rsp_o,
  output logic [DHS_DATAW-1:0] core_0_boot_addr_o,
  output logic [DHS_DATAW-1:0] core_1_boot_addr_o,
  output logic [DHS_DATAW-1:0] core_0_hart_id_o,
  output logic [DHS_DATAW-1:0] core_1_hart_id_o,
  output logic [DHS_DATAW-1:0] gpr0_o,
  output logic [DHS_DATAW-1:0] gpr1_o
);

  localparam logic [OFFSET_W-1:0] CORE0_BOOT_OFS = OFFSET_W'(0);
  localparam logic [OFFSET_W-1:0] CORE0_HART_OFS = OFFSET_W'(1);
  localparam logic [OFFSET_W-1:0] CORE1_BOOT_OFS = OFFSET_W'(2);
  localparam logic [OFFSET_W-1:0] CORE1_HART_OFS = OFFSET_W'(3);
  localparam logic [OFFSET_W-1:0] GPR0_OFS       = OFFSET_W'(4);
  localparam logic [OFFSET_W-1:0] GPR1_OFS       = OFFSET_W'(5);
  localparam logic [OFFSET_W-1:0] BOOT_MODE_OFS  = OFFSET_W'(6);

  logic [OFFSET_W-1:0]  offset;
  logic                 wr_en;
  logic [DHS_DATAW-1:0] core_0_boot_q;
  logic [DHS_DATAW-1:0] core_1_boot_q;
  logic [DHS_DATAW-1:0] core_0_hart_q;
  logic [DHS_DATAW-1:0] core_1_hart_q;
  logic [DHS_DATAW-1:0] gpr0_q;
  logic [DHS_DATAW-1:0] gpr1_q;
  periph_rsp_t          rsp_d;
  periph_rsp_t          rsp_q;

  assign offset = req_i.addr[OFFSET_LSB +: OFFSET_W];
  assign wr_en  = sel_i && req_i.write;

  //////////////////////////////////////////////////
  // Writable registers
  //////////////////////////////////////////////////

  always_ff @(posedge periphl_clk_i) begin
    if (reset_i) begin
      core_0_boot_q <= BOOT_ROM_BASE;
      core_1_boot_q <= BOOT_ROM_BASE;
      core_0_hart_q <= DHS_DATAW'(0);
      core_1_hart_q <= DHS_DATAW'(1);
      gpr0_q        <= '0;
      gpr1_q        <= '0;
    end else if (wr_en) begin
      case (offset)
        CORE0_BOOT_OFS: core_0_boot_q <= req_i.wdata;
        CORE0_HART_OFS: core_0_hart_q <= req_i.wdata;
        CORE1_BOOT_OFS: core_1_boot_q <= req_i.wdata;
        CORE1_HART_OFS: core_1_hart_q <= req_i.wdata;
        GPR0_OFS:       gpr0_q        <= req_i.wdata;
        GPR1_OFS:       gpr1_q        <= req_i.wdata;
        // Boot mode and holes are not writable
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Read and response
  //////////////////////////////////////////////////

  always_comb begin
    rsp_d = '0;
    case (offset)
      CORE0_BOOT_OFS: rsp_d.rdata = core_0_boot_q;
      CORE0_HART_OFS: rsp_d.rdata = core_0_hart_q;
      CORE1_BOOT_OFS: rsp_d.rdata = core_1_boot_q;
      CORE1_HART_OFS: rsp_d.rdata = core_1_hart_q;
      GPR0_OFS:       rsp_d.rdata = gpr0_q;
      GPR1_OFS:       rsp_d.rdata = gpr1_q;
      BOOT_MODE_OFS: begin
        rsp_d.rdata = DHS_DATAW'(boot_mode_i);
        rsp_d.err   = req_i.write;
      end
      default: rsp_d.err = 1'b1;
    endcase
    // Write responses carry no data
    if (req_i.write) begin
      rsp_d.rdata = '0;
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (sel_i) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o              = rsp_q;
  assign core_0_boot_addr_o = core_0_boot_q;
  assign core_1_boot_addr_o = core_1_boot_q;
  assign core_0_hart_id_o   = core_0_hart_q;
  assign core_1_hart_id_o   = core_1_hart_q;
  assign gpr0_o             = gpr0_q;
  assign gpr1_o             = gpr1_q;

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx
  import helix_pkg::*;
(
  input  logic        periphl_clk_i,
  input  logic        reset_i,
  input  logic        sel_i,
  input  periph_req_t req_i,
  output periph_rsp_t rsp_o,
  output logic        uart_tx_o
);

  localparam logic [OFFSET_W-1:0] TXDATA_OFS = OFFSET_W'(0);
  localparam logic [OFFSET_W-1:0] STATUS_OFS = OFFSET_W'(1);

  logic [OFFSET_W-1:0]    offset;
  logic                   wr_txdata;
  logic                   wr_status;
  logic                   push;
  logic                   pop;
  logic                   fifo_full;
  logic                   fifo_empty;
  logic                   tx_busy;
  logic                   bit_end;
  logic [7:0]             fifo_mem [UART_FIFO_DEPTH];
  logic [UART_PTR_W-1:0]  wr_ptr_q;
  logic [UART_PTR_W-1:0]  rd_ptr_q;
  logic [UART_LVL_W-1:0]  level_q;
  logic                   ovf_q;
  logic                   tx_active_q;
  logic [UART_FRAME_BITS-1:0] shift_q;
  logic [UART_BAUD_W-1:0] baud_cnt_q;
  logic [3:0]             bit_cnt_q;
  logic [DHS_DATAW-1:0]   status_word;
  periph_rsp_t            rsp_d;
  periph_rsp_t            rsp_q;

  assign offset     = req_i.addr[OFFSET_LSB +: OFFSET_W];
  assign wr_txdata  = sel_i && req_i.write && (offset == TXDATA_OFS);
  assign wr_status  = sel_i && req_i.write && (offset == STATUS_OFS);
  assign fifo_full  = (level_q == UART_LVL_W'(UART_FIFO_DEPTH));
  assign fifo_empty = (level_q == '0);
  // Bytes that arrive on a full FIFO are dropped
  assign push       = wr_txdata && !fifo_full;
  assign pop        = !tx_active_q && !fifo_empty;
  assign tx_busy    = tx_active_q || !fifo_empty;

  //////////////////////////////////////////////////
  // Holding FIFO
  //////////////////////////////////////////////////

  always_ff @(posedge periphl_clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= req_i.wdata[7:0];
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  // Sticky until software writes STATUS
  always_ff @(posedge periphl_clk_i) begin
    if (reset_i) begin
      ovf_q <= 1'b0;
    end else if (wr_status) begin
      ovf_q <= 1'b0;
    end else if (wr_txdata && fifo_full) begin
      ovf_q <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Register response
  //////////////////////////////////////////////////

  assign status_word = DHS_DATAW'({tx_busy, ovf_q, fifo_full, level_q});

  always_comb begin
    rsp_d     = '0;
    rsp_d.err = (offset != TXDATA_OFS) && (offset != STATUS_OFS);
    if ((offset == STATUS_OFS) && !req_i.write) begin
      rsp_d.rdata = status_word;
    end
  end

  always_ff @(posedge periphl_clk_i) begin
    if (sel_i) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o = rsp_q;

  //////////////////////////////////////////////////
  // 8N1 serializer
  //////////////////////////////////////////////////

  assign bit_end = (baud_cnt_q == UART_BAUD_W'(UART_CLKS_PER_BIT - 1));

  always_ff @(posedge periphl_clk_i) begin
    if (reset_i) begin
      tx_active_q <= 1'b0;
      baud_cnt_q  <= '0;
      bit_cnt_q   <= '0;
    end else if (pop) begin
      tx_active_q <= 1'b1;
      baud_cnt_q  <= '0;
      bit_cnt_q   <= '0;
    end else if (tx_active_q) begin
      if (bit_end) begin
        baud_cnt_q <= '0;
        bit_cnt_q  <= bit_cnt_q + 1'b1;
        // Stop bit done
        if (bit_cnt_q == 4'(UART_FRAME_BITS - 1)) begin
          tx_active_q <= 1'b0;
        end
      end else begin
        baud_cnt_q <= baud_cnt_q + 1'b1;
      end
    end
  end

  // Frame is stop, data LSB first, start; shifted out from bit 0
  always_ff @(posedge periphl_clk_i) begin
    if (pop) begin
      shift_q <= {1'b1, fifo_mem[rd_ptr_q], 1'b0};
    end else if (tx_active_q && bit_end) begin
      shift_q <= {1'b1, shift_q[UART_FRAME_BITS-1:1]};
    end
  end

  assign uart_tx_o = !tx_active_q || shift_q[0];

  // FIFO level stays within its depth
  assert property (@(posedge periphl_clk_i) disable iff (reset_i)
    level_q <= UART_LVL_W'(UART_FIFO_DEPTH));

endmodule

/* logic/helix_periph_top.sv */
`timescale 1ns/1ps

module helix_periph_top
  import helix_pkg::*;
(
  input  logic                 periphl_clk_i,
  input  logic                 reset_i,
  input  logic                 req_valid_i,
  input  periph_req_t          req_i,
  input  logic                 boot_mode_i,
  output logic                 rsp_valid_o,
  output periph_rsp_t          rsp_o,
  output logic [DHS_DATAW-1:0] core_0_boot_addr_o,
  output logic [DHS_DATAW-1:0] core_1_boot_addr_o,
  output logic [DHS_DATAW-1:0] core_0_hart_id_o,
  output logic [DHS_DATAW-1:0] core_1_hart_id_o,
  output logic [DHS_DATAW-1:0] gpr0_o,
  output logic [DHS_DATAW-1:0] gpr1_o,
  output logic                 uart_tx_o
);

  periph_sel_t sel;
  periph_req_t fwd_req;
  periph_rsp_t soc_rsp;
  periph_rsp_t uart_rsp;

  //////////////////////////////////////////////////
  // Peripheral link
  //////////////////////////////////////////////////

  periph_link periph_link_i (
    .periphl_clk_i (periphl_clk_i),
    .reset_i       (reset_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .sel_o         (sel),
    .fwd_req_o     (fwd_req),
    .soc_rsp_i     (soc_rsp),
    .uart_rsp_i    (uart_rsp),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o)
  );

  //////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////

  soc_ctrl_regs soc_ctrl_regs_i (
    .periphl_clk_i      (periphl_clk_i),
    .reset_i            (reset_i),
    .sel_i              (sel.soc_ctrl),
    .req_i              (fwd_req),
    .boot_mode_i        (boot_mode_i),
    .rsp_o              (soc_rsp),
    .core_0_boot_addr_o (core_0_boot_addr_o),
    .core_1_boot_addr_o (core_1_boot_addr_o),
    .core_0_hart_id_o   (core_0_hart_id_o),
    .core_1_hart_id_o   (core_1_hart_id_o),
    .gpr0_o             (gpr0_o),
    .gpr1_o             (gpr1_o)
  );

  uart_tx uart_tx_i (
    .periphl_clk_i (periphl_clk_i),
    .reset_i       (reset_i),
    .sel_i         (sel.uart),
    .req_i         (fwd_req),
    .rsp_o         (uart_rsp),
    .uart_tx_o     (uart_tx_o)
  );

endmodule

/* sim/uart_tx_monitor.sv */
`timescale 1ns/1ps

module uart_tx_monitor
  import helix_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       line_i,
  input  logic       push_i,
  input  logic [7:0] byte_i,
  output int         err_count_o,
  output int         pending_o
);

  logic [7:0] expected_q [$];
  int         pushed_cnt = 0;
  int         popped_cnt = 0;

  assign pending_o = pushed_cnt - popped_cnt;

  always @(posedge clk_i) begin
    if (push_i) begin
      expected_q.push_back(byte_i);
      pushed_cnt <= pushed_cnt + 1;
    end
  end

  // Samples each bit near its middle, counted from the start edge
  task automatic receive_frame();
    logic [7:0] data;
    logic [7:0] want;
    repeat (UART_CLKS_PER_BIT / 2) @(negedge clk_i);
    if (line_i !== 1'b0) begin
      $display("** Error at %0t: start bit is %b, expected 0", $time, line_i);
      err_count_o++;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (UART_CLKS_PER_BIT) @(negedge clk_i);
      data[i] = line_i;
    end
    repeat (UART_CLKS_PER_BIT) @(negedge clk_i);
    if (line_i !== 1'b1) begin
      $display("** Error at %0t: stop bit is %b, expected 1", $time, line_i);
      err_count_o++;
    end
    if (expected_q.size() == 0) begin
      $display("UART sent byte %h at %0t although no accepted write was pending", data, $time);
      err_count_o++;
    end else begin
      want = expected_q.pop_front();
      popped_cnt++;
      if (data !== want) begin
        $display("** Error at %0t: UART byte is %h, expected %h", $time, data, want);
        err_count_o++;
      end
    end
  endtask

  initial begin
    err_count_o = 0;
    forever begin
      @(negedge line_i);
      if (!reset_i) begin
        receive_frame();
      end
    end
  end

endmodule

/* sim/helix_periph_tb.sv */
`timescale 1ns/1ps

module helix_periph_tb
  import helix_pkg::*;
();

  localparam int RESET_CYCLES  = 4;
  localparam int MARGIN_CYCLES = 200;

  // Address fields as the bus map defines them
  localparam logic [3:0] SOC_REGION = 4'd0;
  localparam logic [3:0] TX_REGION  = 4'd1;
  localparam logic [3:0] TX_OFS     = 4'd0;
  localparam logic [3:0] SOC_RW_END = 4'd6;

  typedef struct packed {
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        err;
    logic [31:0] idle;
  } case_t;

  typedef struct packed {
    logic [31:0] due;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        err;
  } expect_t;

  logic                 periphl_clk_i;
  logic                 reset_i;
  logic                 req_valid_i;
  periph_req_t          req_i;
  logic                 boot_mode_i;
  logic                 rsp_valid_o;
  periph_rsp_t          rsp_o;
  logic [DHS_DATAW-1:0] core_0_boot_addr_o;
  logic [DHS_DATAW-1:0] core_1_boot_addr_o;
  logic [DHS_DATAW-1:0] core_0_hart_id_o;
  logic [DHS_DATAW-1:0] core_1_hart_id_o;
  logic [DHS_DATAW-1:0] gpr0_o;
  logic [DHS_DATAW-1:0] gpr1_o;
  logic                 uart_tx_o;

  // Expected response, travels with the strobe
  periph_rsp_t drv_exp;

  case_t   cases [$];
  expect_t exp_q [$];
  expect_t new_exp;
  expect_t rsp_exp;
  int      cycle_cnt    = 0;
  int      cycle_limit  = 1000000;
  int      rsp_errors   = 0;
  int      setup_errors = 0;
  int      uart_errors;
  int      uart_pending;

  // Shadow of the UART FIFO and serializer
  logic       sel_tx;
  logic [7:0] sel_byte;
  logic       m_pop;
  logic       m_active;
  int         m_level;
  int         m_left;
  logic       mon_push = 1'b0;
  logic [7:0] mon_byte;

  helix_periph_top helix_periph_top_i (
    .periphl_clk_i      (periphl_clk_i),
    .reset_i            (reset_i),
    .req_valid_i        (req_valid_i),
    .req_i              (req_i),
    .boot_mode_i        (boot_mode_i),
    .rsp_valid_o        (rsp_valid_o),
    .rsp_o              (rsp_o),
    .core_0_boot_addr_o (core_0_boot_addr_o),
    .core_1_boot_addr_o (core_1_boot_addr_o),
    .core_0_hart_id_o   (core_0_hart_id_o),
    .core_1_hart_id_o   (core_1_hart_id_o),
    .gpr0_o             (gpr0_o),
    .gpr1_o             (gpr1_o),
    .uart_tx_o          (uart_tx_o)
  );

  uart_tx_monitor monitor_i (
    .clk_i       (periphl_clk_i),
    .reset_i     (reset_i),
    .line_i      (uart_tx_o),
    .push_i      (mon_push),
    .byte_i      (mon_byte),
    .err_count_o (uart_errors),
    .pending_o   (uart_pending)
  );

  always #4 periphl_clk_i = ~periphl_clk_i;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic is_txdata(logic [31:0] addr);
    return (addr[15:12] == TX_REGION) && (addr[5:2] == TX_OFS);
  endfunction

  function automatic logic [31:0] soc_output(logic [3:0] offset);
    case (offset)
      4'd0:    return core_0_boot_addr_o;
      4'd1:    return core_0_hart_id_o;
      4'd2:    return core_1_boot_addr_o;
      4'd3:    return core_1_hart_id_o;
      4'd4:    return gpr0_o;
      default: return gpr1_o;
    endcase
  endfunction

  function automatic void report_mismatch(string what, logic [31:0] got, logic [31:0] want);
    $display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
  endfunction

  function automatic int cycle_budget();
    int cycles;
    int bytes;
    cycles = 0;
    bytes  = 0;
    foreach (cases[i]) begin
      if (cases[i].op == "B") begin
        cycles += cases[i].idle;
        bytes  += cases[i].idle;
      end else begin
        cycles += 1 + cases[i].idle;
        if (cases[i].op == "W" && is_txdata(cases[i].addr)) begin
          bytes++;
        end
      end
    end
    return cycles + bytes * 10 * UART_CLKS_PER_BIT + MARGIN_CYCLES;
  endfunction

  task automatic load_cases(output logic ok);
    int          fd;
    int          n;
    string       line;
    case_t       c;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        err;
    logic [31:0] idle;
    ok = 1'b0;
    fd = $fopen("sim/periph_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the cases file sim/periph_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h %h %h %d", op, addr, wdata, rdata, err, idle);
          if (n == 6) begin
            c = '{op: op, addr: addr, wdata: wdata, rdata: rdata, err: err, idle: idle};
            cases.push_back(c);
          end else begin
            $display("Cannot parse case line: %s", line);
          end
        end
      end
      $fclose(fd);
      ok = (cases.size() > 0);
    end
  endtask

  task automatic finish_run(input logic aborted);
    int checks;
    checks = rsp_errors + setup_errors;
    $display("Run ended: %0d check errors, %0d UART errors", checks, uart_errors);
    if (aborted || checks != 0 || uart_errors != 0) begin
      $display("ERRORS FOUND");
    end else begin
      $display("NO ERRORS");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic issue(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
                       input logic [31:0] rdata, input logic err);
    @(posedge periphl_clk_i);
    req_valid_i   <= 1'b1;
    req_i.write   <= write;
    req_i.addr    <= addr;
    req_i.wdata   <= wdata;
    drv_exp.err   <= err;
    drv_exp.rdata <= rdata;
  endtask

  task automatic go_idle(input int n);
    repeat (n) begin
      @(posedge periphl_clk_i);
      req_valid_i <= 1'b0;
    end
  endtask

  task automatic run_cases();
    case_t c;
    foreach (cases[i]) begin
      c = cases[i];
      if (c.op == "B") begin
        // Back-to-back writes, data counts up from the given word
        for (int k = 0; k < c.idle; k++) begin
          issue(1'b1, c.addr, c.wdata + k, c.rdata, c.err);
        end
      end else begin
        issue(c.op == "W", c.addr, c.wdata, c.rdata, c.err);
        go_idle(c.idle);
      end
    end
    go_idle(1);
  endtask

  task automatic check_reset_outputs();
    logic [DHS_DATAW-1:0] want [6];
    want = '{BOOT_ROM_BASE, 32'd0, BOOT_ROM_BASE, 32'd1, 32'd0, 32'd0};
    for (int i = 0; i < 6; i++) begin
      if (soc_output(4'(i)) !== want[i]) begin
        report_mismatch($sformatf("SoC register output %0d after reset", i),
                        soc_output(4'(i)), want[i]);
        setup_errors++;
      end
    end
    if (uart_tx_o !== 1'b1) begin
      report_mismatch("uart_tx_o after reset", 32'(uart_tx_o), 32'd1);
      setup_errors++;
    end
    if (rsp_valid_o !== 1'b0) begin
      report_mismatch("rsp_valid_o after reset", 32'(rsp_valid_o), 32'd0);
      setup_errors++;
    end
  endtask

  initial begin
    logic ok;
    periphl_clk_i = 1'b0;
    reset_i       = 1'b1;
    req_valid_i   = 1'b0;
    req_i         = '0;
    boot_mode_i   = 1'b1;
    drv_exp       = '0;
    load_cases(ok);
    if (!ok) begin
      $display("No usable cases were loaded");
      finish_run(1'b1);
    end else begin
      cycle_limit = cycle_budget();
      repeat (RESET_CYCLES) @(posedge periphl_clk_i);
      reset_i <= 1'b0;
      @(negedge periphl_clk_i);
      check_reset_outputs();
      run_cases();
      // Drain outstanding responses and serial frames
      while (exp_q.size() > 0 || uart_pending > 0 || m_active || m_level > 0) begin
        @(posedge periphl_clk_i);
      end
      repeat (2) @(posedge periphl_clk_i);
      finish_run(1'b0);
    end
  end

  //////////////////////////////////////////////////
  // Response checks
  //////////////////////////////////////////////////

  task automatic check_response(input expect_t e);
    if (e.due != cycle_cnt) begin
      $display("** Error at %0t: response for %h came at cycle %0d, expected %0d",
               $time, e.addr, cycle_cnt, e.due);
      rsp_errors++;
    end
    if (rsp_o.err !== e.err) begin
      report_mismatch($sformatf("error flag for %h", e.addr), 32'(rsp_o.err), 32'(e.err));
      rsp_errors++;
    end
    if (rsp_o.rdata !== e.rdata) begin
      report_mismatch($sformatf("read data for %h", e.addr), rsp_o.rdata, e.rdata);
      rsp_errors++;
    end
    // A good write shows on its register output with the response
    if (e.write && !e.err && e.addr[15:12] == SOC_REGION && e.addr[5:2] < SOC_RW_END) begin
      if (soc_output(e.addr[5:2]) !== e.wdata) begin
        report_mismatch($sformatf("output for %h", e.addr), soc_output(e.addr[5:2]), e.wdata);
        rsp_errors++;
      end
    end
  endtask

  always @(negedge periphl_clk_i) begin
    if (!reset_i) begin
      if (req_valid_i) begin
        new_exp = '{due: cycle_cnt + 2, write: req_i.write, addr: req_i.addr,
                    wdata: req_i.wdata, rdata: drv_exp.rdata, err: drv_exp.err};
        exp_q.push_back(new_exp);
      end
      if (rsp_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("Response at %0t with no request outstanding", $time);
          rsp_errors++;
        end else begin
          rsp_exp = exp_q.pop_front();
          check_response(rsp_exp);
        end
      end else if (exp_q.size() > 0 && exp_q[0].due <= cycle_cnt) begin
        rsp_exp = exp_q.pop_front();
        $display("No response arrived for the request to %h", rsp_exp.addr);
        rsp_errors++;
      end
    end
  end

  //////////////////////////////////////////////////
  // UART shadow model
  //////////////////////////////////////////////////

  always @(negedge periphl_clk_i) begin
    mon_push <= 1'b0;
    if (reset_i) begin
      sel_tx   = 1'b0;
      sel_byte = 8'h00;
      m_active = 1'b0;
      m_level  = 0;
      m_left   = 0;
    end else begin
      m_pop = !m_active && (m_level > 0);
      // Bytes reaching a full FIFO are lost
      if (sel_tx && m_level < UART_FIFO_DEPTH) begin
        mon_push <= 1'b1;
        mon_byte <= sel_byte;
        m_level++;
      end
      if (m_pop) begin
        m_level--;
        m_active = 1'b1;
        m_left   = 10 * UART_CLKS_PER_BIT;
      end else if (m_active) begin
        m_left--;
        if (m_left == 0) begin
          m_active = 1'b0;
        end
      end
      sel_tx   = req_valid_i && req_i.write && is_txdata(req_i.addr);
      sel_byte = req_i.wdata[7:0];
    end
  end

  always @(posedge periphl_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, %0d responses and %0d UART bytes still expected",
               cycle_cnt, exp_q.size(), uart_pending);
      finish_run(1'b1);
    end
  end

endmodule

/* sim/periph_cases.txt */
# op addr wdata exp_rdata exp_err idle  (op W write, R read, B back-to-back writes)
# hex fields except idle; for B the last column is the number of writes, data counts up
R 00000000 00000000 10000000 0 0
R 00000004 00000000 00000000 0 0
R 00000008 00000000 10000000 0 0
R 0000000c 00000000 00000001 0 0
R 00000010 00000000 00000000 0 0
R 00000014 00000000 00000000 0 0
R 00001004 00000000 00000000 0 3
W 00000000 20000000 00000000 0 2
W 00000004 00000005 00000000 0 0
W 00000008 20000400 00000000 0 0
W 0000000c 00000006 00000000 0 0
W 00000010 deadbeef 00000000 0 0
W 00000014 0badf00d 00000000 0 1
W 00000018 00000000 00000000 1 1
R 00000018 00000000 00000001 0 1
R 00000000 00000000 20000000 0 0
R 00002000 00000000 00000000 1 0
R 00000004 00000000 00000005 0 0
R 0000f01c 00000000 00000000 1 0
R 00000008 00000000 20000400 0 0
W 00003010 12345678 00000000 1 0
R 0000000c 00000000 00000006 0 0
R 00001008 00000000 00000000 1 0
R 00000010 00000000 deadbeef 0 0
R 00000014 00000000 0badf00d 0 0
R 0000001c 00000000 00000000 1 3
W 00001000 000000a5 00000000 0 90
W 00001000 0000003c 00000000 0 100
B 00001000 00000011 00000000 0 7
R 00001004 00000000 0000003c 0 0
W 00001004 00000000 00000000 0 0
R 00001004 00000000 0000002c 0 2

/* project.f */
logic/helix_pkg.sv
logic/periph_link.sv
logic/soc_ctrl_regs.sv
logic/uart_tx.sv
logic/helix_periph_top.sv
sim/uart_tx_monitor.sv
sim/helix_periph_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module helix_periph_tb -o helix_periph_tb
./obj_dir/helix_periph_tb | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
